// ==== design/noc_pkg.sv ====
package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Up to 4 virtual channels
  localparam int VC_ID_W   = 2;
  localparam int PAYLOAD_W = 32;

  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'd0,
    FLIT_BODY   = 2'd1,
    FLIT_TAIL   = 2'd2,
    // One-flit packet, head and tail at once
    FLIT_SINGLE = 2'd3
  } flit_kind_e;

  typedef struct packed {
    flit_kind_e           kind;
    logic [VC_ID_W-1:0]   vc_id;
    logic [PAYLOAD_W-1:0] payload;
  } noc_flit_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output arbiter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet boundary tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic is_head(input flit_kind_e kind);
    logic result;
    result = (kind == FLIT_HEAD) || (kind == FLIT_SINGLE);
    return result;
  endfunction

  function automatic logic is_tail(input flit_kind_e kind);
    logic result;
    result = (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
    return result;
  endfunction

endpackage

// ==== design/flit_fifo_core.sv ====
`timescale 1ns/1ps

module flit_fifo_core import noc_pkg::*; #(
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH - 1
) (
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_clear,
  input  logic      i_push,
  input  noc_flit_t i_data,
  input  logic      i_pop,
  output noc_flit_t o_data,
  output logic      o_empty,
  output logic      o_almost_full,
  output logic      o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_flit_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push_ok;
  logic             pop_ok;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] next;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      next = '0;
    end else begin
      next = ptr + 1'b1;
    end
    return next;
  endfunction

  // Flags are registered, so they match count
  assign push_ok = i_push && !o_full;
  assign pop_ok  = i_pop && !o_empty;

  always_comb begin
    count_next = count;
    if (i_clear) begin
      count_next = '0;
    end else if (push_ok && !pop_ok) begin
      count_next = count + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_empty       <= 1'b1;
      o_almost_full <= (THRESHOLD <= 0);
      o_full        <= 1'b0;
    end else begin
      if (i_clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (push_ok) begin
          wr_ptr <= ptr_inc(wr_ptr);
        end
        if (pop_ok) begin
          rd_ptr <= ptr_inc(rd_ptr);
        end
      end
      count         <= count_next;
      o_empty       <= (count_next == '0);
      o_almost_full <= (int'(count_next) >= THRESHOLD);
      o_full        <= (int'(count_next) == DEPTH);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Head of queue read straight out
  assign o_data = mem[rd_ptr];

endmodule

// ==== design/vc_flit_buffer.sv ====
`timescale 1ns/1ps

module vc_flit_buffer import noc_pkg::*; #(
  parameter int CHANNELS  = 2,
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH - 1
) (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic                     i_in_valid,
  input  noc_flit_t                i_in_flit,
  input  logic      [CHANNELS-1:0] i_pop,
  output logic      [CHANNELS-1:0] o_in_ready,
  output logic      [CHANNELS-1:0] o_in_vc_available,
  output logic      [CHANNELS-1:0] o_empty,
  output noc_flit_t [CHANNELS-1:0] o_head
);

  logic [CHANNELS-1:0] push;
  logic [CHANNELS-1:0] empty;
  logic [CHANNELS-1:0] almost_full;
  logic [CHANNELS-1:0] full;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Upstream flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_in_ready        = ~full;
  assign o_in_vc_available = ~almost_full;
  assign o_empty           = empty;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One FIFO per virtual channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar c = 0; c < CHANNELS; c++) begin : g_vc
    // Steer by channel field, a full FIFO drops the flit itself
    assign push[c] = i_in_valid && (i_in_flit.vc_id == VC_ID_W'(c));

    flit_fifo_core #(
      .DEPTH     (DEPTH),
      .THRESHOLD (THRESHOLD)
    ) u_fifo (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_clear       (i_clear),
      .i_push        (push[c]),
      .i_data        (i_in_flit),
      .i_pop         (i_pop[c]),
      .o_data        (o_head[c]),
      .o_empty       (empty[c]),
      .o_almost_full (almost_full[c]),
      .o_full        (full[c])
    );
  end

endmodule

// ==== design/vc_output_arbiter.sv ====
`timescale 1ns/1ps

module vc_output_arbiter import noc_pkg::*; #(
  parameter int CHANNELS = 2
) (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_clear,
  input  logic      [CHANNELS-1:0] i_empty,
  input  noc_flit_t [CHANNELS-1:0] i_head,
  input  logic      [CHANNELS-1:0] i_out_ready,
  output logic      [CHANNELS-1:0] o_pop,
  output logic                     o_out_valid,
  output noc_flit_t                o_out_flit
);

  localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  arb_state_e      state;
  logic [CH_W-1:0] ptr;
  logic [CH_W-1:0] lock_sel;
  logic            idle_found;
  logic [CH_W-1:0] idle_sel;
  logic [CH_W-1:0] sel;
  logic [CH_W-1:0] sel_past;
  logic            sel_valid;
  logic            xfer;
  logic            xfer_tail;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant, combinational
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Scan downward so the nearest channel at or after ptr wins
  always_comb begin
    int idx;
    idle_found = 1'b0;
    idle_sel   = '0;
    for (int i = CHANNELS - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % CHANNELS;
      if (!i_empty[idx]) begin
        idle_found = 1'b1;
        idle_sel   = CH_W'(idx);
      end
    end
  end

  assign sel       = (state == ARB_LOCKED) ? lock_sel : idle_sel;
  assign sel_valid = (state == ARB_LOCKED) ? !i_empty[lock_sel] : idle_found;
  assign sel_past  = (int'(sel) == CHANNELS - 1) ? '0 : sel + 1'b1;
  assign xfer      = sel_valid && i_out_ready[sel];
  assign xfer_tail = xfer && is_tail(o_out_flit.kind);

  assign o_out_valid = sel_valid;
  assign o_out_flit  = i_head[sel];

  always_comb begin
    o_pop      = '0;
    o_pop[sel] = xfer;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lock state and rotation pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A stalled head also locks, so the offered flit holds steady
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= ARB_IDLE;
      ptr      <= '0;
      lock_sel <= '0;
    end else if (i_clear) begin
      state <= ARB_IDLE;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (xfer_tail) begin
            ptr <= sel_past;
          end else if (sel_valid) begin
            state    <= ARB_LOCKED;
            lock_sel <= sel;
          end
        end
        ARB_LOCKED: begin
          // Release only on the tail
          if (xfer_tail) begin
            state <= ARB_IDLE;
            ptr   <= sel_past;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

endmodule

// ==== design/noc_input_unit.sv ====
`timescale 1ns/1ps

module noc_input_unit import noc_pkg::*; #(
  parameter int CHANNELS  = 2,
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH - 1
) (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_clear,
  input  logic                i_in_valid,
  input  noc_flit_t           i_in_flit,
  input  logic [CHANNELS-1:0] i_out_ready,
  output logic [CHANNELS-1:0] o_in_ready,
  output logic [CHANNELS-1:0] o_in_vc_available,
  output logic                o_out_valid,
  output noc_flit_t           o_out_flit
);

  // Bank to arbiter
  logic      [CHANNELS-1:0] empty;
  noc_flit_t [CHANNELS-1:0] head;
  logic      [CHANNELS-1:0] pop;

  vc_flit_buffer #(
    .CHANNELS  (CHANNELS),
    .DEPTH     (DEPTH),
    .THRESHOLD (THRESHOLD)
  ) u_buffer (
    .clk               (clk),
    .i_rst_n           (i_rst_n),
    .i_clear           (i_clear),
    .i_in_valid        (i_in_valid),
    .i_in_flit         (i_in_flit),
    .i_pop             (pop),
    .o_in_ready        (o_in_ready),
    .o_in_vc_available (o_in_vc_available),
    .o_empty           (empty),
    .o_head            (head)
  );

  vc_output_arbiter #(
    .CHANNELS (CHANNELS)
  ) u_arbiter (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_clear     (i_clear),
    .i_empty     (empty),
    .i_head      (head),
    .i_out_ready (i_out_ready),
    .o_pop       (pop),
    .o_out_valid (o_out_valid),
    .o_out_flit  (o_out_flit)
  );

endmodule

// ==== testbench/vc_buffer_chk.sv ====
`timescale 1ns/1ps

module vc_buffer_chk #(
  parameter int CHANNELS = 2
) (
  input logic                clk,
  input logic                i_rst_n,
  input logic [CHANNELS-1:0] i_push,
  input logic [CHANNELS-1:0] i_full,
  input logic [CHANNELS-1:0] i_pop,
  input logic [CHANNELS-1:0] i_empty
);

  int fail_count = 0;

  // Upstream must wait for ready on the flit's channel
  push_not_full: assert property (
    @(posedge clk) disable iff (!i_rst_n) (i_push & i_full) == '0
  ) else begin
    fail_count++;
    $error("flit pushed into a full FIFO");
  end

  pop_not_empty: assert property (
    @(posedge clk) disable iff (!i_rst_n) (i_pop & i_empty) == '0
  ) else begin
    fail_count++;
    $error("pop from an empty FIFO");
  end

  // At most one channel drained per cycle
  pop_onehot: assert property (
    @(posedge clk) disable iff (!i_rst_n) $onehot0(i_pop)
  ) else begin
    fail_count++;
    $error("pop vector has more than one bit set");
  end

endmodule

// ==== testbench/tb_scoreboard.sv ====
`timescale 1ns/1ps

module tb_scoreboard import noc_pkg::*; #(
  parameter int CHANNELS  = 2,
  parameter int DEPTH     = 4,
  parameter int THRESHOLD = DEPTH - 1
) (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_clear,
  input  logic                i_in_valid,
  input  noc_flit_t           i_in_flit,
  input  logic [CHANNELS-1:0] i_in_ready,
  input  logic [CHANNELS-1:0] i_in_vc_available,
  input  logic [CHANNELS-1:0] i_out_ready,
  input  logic                i_out_valid,
  input  noc_flit_t           i_out_flit,
  output logic [CHANNELS-1:0] o_model_full,
  output logic [CHANNELS-1:0] o_model_empty,
  output int                  o_error_count,
  output int                  o_flit_count
);

  noc_flit_t           model_q [CHANNELS][$];
  noc_flit_t           stall_flit;
  logic                stall_pending = 1'b0;
  logic                in_packet = 1'b0;
  logic                clear_seen = 1'b0;
  int                  lock_vc = 0;
  int                  errors = 0;
  int                  flits = 0;
  logic [CHANNELS-1:0] full_v = '0;
  logic [CHANNELS-1:0] empty_v = '1;

  assign o_model_full  = full_v;
  assign o_model_empty = empty_v;
  assign o_error_count = errors;
  assign o_flit_count  = flits;

  task automatic log_mismatch(input string sig, input logic [63:0] exp_v,
                              input logic [63:0] got_v);
    errors++;
    $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, sig, exp_v, got_v);
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic check_idle_outputs();
    if (i_out_valid !== 1'b0) log_mismatch("o_out_valid", 64'd0, 64'(i_out_valid));
    if (i_in_ready !== '1) begin
      log_mismatch("o_in_ready", 64'({CHANNELS{1'b1}}), 64'(i_in_ready));
    end
    if (i_in_vc_available !== '1) begin
      log_mismatch("o_in_vc_available", 64'({CHANNELS{1'b1}}), 64'(i_in_vc_available));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output order, data and packet lock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_output(input int vc);
    noc_flit_t exp_flit;
    flits++;
    if (in_packet && vc != lock_vc) log_mismatch("o_out_flit.vc_id", 64'(lock_vc), 64'(vc));
    if (model_q[vc].size() == 0) begin
      fail_check($sformatf("flit left the DUT on channel %0d with nothing queued", vc));
    end else begin
      exp_flit = model_q[vc].pop_front();
      if (i_out_flit.kind != exp_flit.kind) begin
        log_mismatch("o_out_flit.kind", 64'(exp_flit.kind), 64'(i_out_flit.kind));
      end
      if (i_out_flit.vc_id != exp_flit.vc_id) begin
        log_mismatch("o_out_flit.vc_id", 64'(exp_flit.vc_id), 64'(i_out_flit.vc_id));
      end
      if (i_out_flit.payload != exp_flit.payload) begin
        log_mismatch("o_out_flit.payload", 64'(exp_flit.payload), 64'(i_out_flit.payload));
      end
      // A single flit opens and closes its packet at once
      if (exp_flit.kind == FLIT_TAIL || exp_flit.kind == FLIT_SINGLE) begin
        in_packet = 1'b0;
      end else if (exp_flit.kind == FLIT_HEAD) begin
        in_packet = 1'b1;
        lock_vc   = vc;
      end
    end
  endtask

  task automatic observe_edge();
    int out_vc;
    int in_vc;
    out_vc = int'(i_out_flit.vc_id);
    in_vc  = int'(i_in_flit.vc_id);
    if (!i_rst_n) begin
      for (int c = 0; c < CHANNELS; c++) model_q[c].delete();
      stall_pending = 1'b0;
      in_packet     = 1'b0;
      clear_seen    = 1'b0;
    end else begin
      // Flit held steady after a stalled cycle
      if (stall_pending && !i_out_valid) begin
        log_mismatch("o_out_valid", 64'd1, 64'd0);
      end else if (stall_pending && i_out_flit != stall_flit) begin
        log_mismatch("o_out_flit", 64'(stall_flit), 64'(i_out_flit));
      end
      stall_pending = 1'b0;
      if (i_out_valid && out_vc >= CHANNELS) begin
        fail_check($sformatf("output flit names channel %0d, which does not exist", out_vc));
      end else if (i_out_valid && i_out_ready[out_vc]) begin
        check_output(out_vc);
      end else if (i_out_valid && !i_clear) begin
        stall_pending = 1'b1;
        stall_flit    = i_out_flit;
      end
      if (i_in_valid && in_vc < CHANNELS && i_in_ready[in_vc]) begin
        model_q[in_vc].push_back(i_in_flit);
      end
      if (i_clear) begin
        for (int c = 0; c < CHANNELS; c++) model_q[c].delete();
        in_packet  = 1'b0;
        clear_seen = 1'b1;
      end
    end
    for (int c = 0; c < CHANNELS; c++) begin
      full_v[c]  = (model_q[c].size() == DEPTH);
      empty_v[c] = (model_q[c].size() == 0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Upstream flags checked mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_flags();
    int   cnt;
    logic exp_ready;
    logic exp_avail;
    if (!i_rst_n) begin
      check_idle_outputs();
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        cnt       = model_q[c].size();
        exp_ready = (cnt != DEPTH);
        exp_avail = (cnt < THRESHOLD);
        if (i_in_ready[c] !== exp_ready) begin
          log_mismatch($sformatf("o_in_ready[%0d]", c), 64'(exp_ready), 64'(i_in_ready[c]));
        end
        if (i_in_vc_available[c] !== exp_avail) begin
          log_mismatch($sformatf("o_in_vc_available[%0d]", c), 64'(exp_avail),
                       64'(i_in_vc_available[c]));
        end
      end
      if (clear_seen) begin
        check_idle_outputs();
        clear_seen = 1'b0;
      end
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      observe_edge();
      @(negedge clk);
      check_flags();
    end
  end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import noc_pkg::*; ();

  localparam int CHANNELS       = 2;
  localparam int DEPTH          = 4;
  localparam int THRESHOLD      = 3;
  localparam int FLITS_TO_SEND  = 400;
  localparam int CLEAR_AT       = FLITS_TO_SEND / 2;
  localparam int TIMEOUT_CYCLES = FLITS_TO_SEND * 20;

  logic                clk;
  logic                rst_n;
  logic                clear;
  logic                in_valid;
  noc_flit_t           in_flit;
  logic [CHANNELS-1:0] out_ready;
  logic [CHANNELS-1:0] in_ready;
  logic [CHANNELS-1:0] in_vc_available;
  logic                out_valid;
  noc_flit_t           out_flit;
  logic [CHANNELS-1:0] model_full;
  logic [CHANNELS-1:0] model_empty;
  int                  sb_errors;
  int                  flits_out;

  logic [31:0] rng_state;
  int          sent = 0;
  int          cycles = 0;
  logic        clear_done;
  int          pkt_left [CHANNELS];

  noc_input_unit #(
    .CHANNELS  (CHANNELS),
    .DEPTH     (DEPTH),
    .THRESHOLD (THRESHOLD)
  ) noc_input_unit_i (
    .clk               (clk),
    .i_rst_n           (rst_n),
    .i_clear           (clear),
    .i_in_valid        (in_valid),
    .i_in_flit         (in_flit),
    .i_out_ready       (out_ready),
    .o_in_ready        (in_ready),
    .o_in_vc_available (in_vc_available),
    .o_out_valid       (out_valid),
    .o_out_flit        (out_flit)
  );

  tb_scoreboard #(
    .CHANNELS  (CHANNELS),
    .DEPTH     (DEPTH),
    .THRESHOLD (THRESHOLD)
  ) u_scoreboard (
    .clk               (clk),
    .i_rst_n           (rst_n),
    .i_clear           (clear),
    .i_in_valid        (in_valid),
    .i_in_flit         (in_flit),
    .i_in_ready        (in_ready),
    .i_in_vc_available (in_vc_available),
    .i_out_ready       (out_ready),
    .i_out_valid       (out_valid),
    .i_out_flit        (out_flit),
    .o_model_full      (model_full),
    .o_model_empty     (model_empty),
    .o_error_count     (sb_errors),
    .o_flit_count      (flits_out)
  );

  bind vc_flit_buffer vc_buffer_chk #(
    .CHANNELS (CHANNELS)
  ) u_buffer_chk (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_push  (push),
    .i_full  (full),
    .i_pop   (i_pop),
    .i_empty (empty)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d flits sent, model queues did not drain",
               cycles, sent);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic int draw_below(input int n);
    logic [31:0] r;
    r = draw();
    return int'(r % 32'(n));
  endfunction

  function automatic logic packets_open();
    logic open;
    open = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (pkt_left[c] != 0) open = 1'b1;
    end
    return open;
  endfunction

  // One cycle of stimulus after the falling edge
  task automatic drive_cycle();
    int        ch;
    int        len;
    noc_flit_t flit;
    clear    = 1'b0;
    in_valid = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      out_ready[c] = (draw_below(10) >= 3);
    end
    if (sent >= CLEAR_AT && !clear_done && !packets_open()) begin
      clear      = 1'b1;
      clear_done = 1'b1;
    end else if (draw_below(4) != 0) begin
      ch = draw_below(CHANNELS);
      // New packets only while the flit budget lasts
      if (!model_full[ch] && (pkt_left[ch] != 0 || sent < FLITS_TO_SEND)) begin
        flit.vc_id   = VC_ID_W'(ch);
        flit.payload = draw();
        if (pkt_left[ch] == 0) begin
          len          = 1 + draw_below(4);
          flit.kind    = (len == 1) ? FLIT_SINGLE : FLIT_HEAD;
          pkt_left[ch] = len - 1;
        end else begin
          flit.kind    = (pkt_left[ch] == 1) ? FLIT_TAIL : FLIT_BODY;
          pkt_left[ch] = pkt_left[ch] - 1;
        end
        in_flit  = flit;
        in_valid = 1'b1;
        sent++;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int chk_fails;
    int total;
    rst_n      = 1'b0;
    clear      = 1'b0;
    in_valid   = 1'b0;
    in_flit    = '0;
    out_ready  = '0;
    rng_state  = 32'd56840;
    clear_done = 1'b0;
    for (int c = 0; c < CHANNELS; c++) pkt_left[c] = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (sent < FLITS_TO_SEND || packets_open() || !clear_done) begin
      @(negedge clk);
      drive_cycle();
    end
    @(negedge clk);
    clear     = 1'b0;
    in_valid  = 1'b0;
    out_ready = '1;
    // Drain with downstream always ready
    while (model_empty != '1) @(negedge clk);
    @(negedge clk);
    #1;
    chk_fails = noc_input_unit_i.u_buffer.u_buffer_chk.fail_count;
    total     = sb_errors + chk_fails;
    $display("Errors: %0d (scoreboard %0d, assertions %0d), flits sent %0d, flits out %0d",
             total, sb_errors, chk_fails, sent, flits_out);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
design/noc_pkg.sv
design/flit_fifo_core.sv
design/vc_flit_buffer.sv
design/vc_output_arbiter.sv
design/noc_input_unit.sv
testbench/vc_buffer_chk.sv
testbench/tb_scoreboard.sv
testbench/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_top
FILE_LIST := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
